//--- src/slink_reg_pkg.sv
// Register map of the serial-link APB block.
// Offsets, field layouts, reset values and the request that the
// APB front end hands to every register block.

package slink_reg_pkg;

  // --------------------------------------------------
  // bus widths
  // --------------------------------------------------
  localparam int REG_ADDR_W = 8;
  localparam int REG_DATA_W = 32;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [REG_DATA_W-1:0] reg_data_t;

  // registered access, wr_en is a one-cycle strobe
  typedef struct packed {
    reg_addr_t addr;
    reg_data_t wdata;
    logic      wr_en;
  } reg_req_t;

  // --------------------------------------------------
  // register offsets
  // --------------------------------------------------
  localparam reg_addr_t OFS_APB_APP_ENABLE   = 8'h00;
  localparam reg_addr_t OFS_AXI_APP_ENABLE   = 8'h04;
  localparam reg_addr_t OFS_INT_APP_ENABLE   = 8'h08;
  localparam reg_addr_t OFS_INTERRUPT_STATUS = 8'h0c;
  localparam reg_addr_t OFS_PSTATE_CONTROL   = 8'h10;
  localparam reg_addr_t OFS_APB_CREDIT_IDS   = 8'h14;
  localparam reg_addr_t OFS_INT_CREDIT_IDS   = 8'h18;
  // 0x1c left unmapped
  localparam reg_addr_t OFS_DEBUG_BUS_CTRL   = 8'h20;
  localparam reg_addr_t OFS_DEBUG_BUS_STATUS = 8'h24;

  // --------------------------------------------------
  // field layouts
  // --------------------------------------------------
  // occupies bits 19:0, tick in the low byte
  typedef struct packed {
    logic       ctrl_enable;
    logic [2:0] pstate_req;
    logic [7:0] inactivity_count;
    logic [7:0] tick_1us;
  } pstate_ctrl_t;

  // cr_id in the low byte
  typedef struct packed {
    logic [7:0] nack_id;
    logic [7:0] ack_id;
    logic [7:0] crack_id;
    logic [7:0] cr_id;
  } credit_ids_t;

  // enable bit left clear here, the top sets it from its parameter
  localparam pstate_ctrl_t PSTATE_RESET = '{
    ctrl_enable: 1'b0, pstate_req: 3'h2, inactivity_count: 8'h05, tick_1us: 8'h27};

  localparam credit_ids_t APB_IDS_RESET = '{
    nack_id: 8'h23, ack_id: 8'h22, crack_id: 8'h21, cr_id: 8'h20};

  localparam credit_ids_t INT_IDS_RESET = '{
    nack_id: 8'h33, ack_id: 8'h32, crack_id: 8'h31, cr_id: 8'h30};

  // write strobe aimed at one offset
  function automatic logic reg_wr_hit(reg_req_t r, reg_addr_t ofs);
    return r.wr_en && (r.addr == ofs);
  endfunction

endpackage

//--- src/slink_link_pkg.sv
// Link-side types of the register block.
// Application enables, nack event flags and the debug bus select.

package slink_link_pkg;

  // number of application layers and their index in vectors
  localparam int NUM_APPS = 3;
  localparam int APP_APB  = 0;
  localparam int APP_AXI  = 1;
  localparam int APP_INT  = 2;

  typedef struct packed {
    logic apb;
    logic axi;
    logic int_app;
  } app_enable_t;

  // bit 0 is the value, bit 1 picks register over external input
  typedef struct packed {
    logic override_sel;
    logic value;
  } enable_reg_t;

  // apb_seen is bit 0
  typedef struct packed {
    logic int_sent;
    logic int_seen;
    logic apb_sent;
    logic apb_seen;
  } nack_flags_t;

  typedef enum logic [1:0] {
    DBG_APB  = 2'd0,
    DBG_AXI  = 2'd1,
    DBG_INT  = 2'd2,
    DBG_RSVD = 2'd3
  } debug_sel_t;

endpackage

//--- src/slink_apb_front.sv
// APB slave front end without wait states.
// Captures address and write data while PSEL is high and turns the
// setup/access sequence into a one-cycle write strobe for the registers.

`timescale 1ns/100ps

module slink_apb_front (
  input  logic                     RegClk,
  input  logic                     RegReset,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  slink_reg_pkg::reg_addr_t paddr,
  input  slink_reg_pkg::reg_data_t pwdata,
  output slink_reg_pkg::reg_req_t  req
);

  import slink_reg_pkg::*;

  reg_addr_t addr_q;
  reg_data_t wdata_q;
  logic      wr_setup_q;

  // captured address and setup-phase write flag
  always_ff @(posedge RegClk or posedge RegReset) begin
    if (RegReset) begin
      addr_q     <= '0;
      wr_setup_q <= 1'b0;
    end else begin
      if (psel) begin
        addr_q <= paddr;
      end
      wr_setup_q <= psel & pwrite;
    end
  end

  always_ff @(posedge RegClk) begin
    if (psel) begin
      wdata_q <= pwdata;
    end
  end

  // strobe lands in the access cycle and regs update on its closing edge
  assign req = '{addr: addr_q, wdata: wdata_q, wr_en: wr_setup_q & penable};

  // access phase only ever directly follows a setup phase
  a_access_after_setup: assert property (
    @(posedge RegClk) disable iff (RegReset)
    penable |-> psel && $past(psel)
  );

endmodule

//--- src/slink_field_reg.sv
// Generic writable configuration register at a fixed offset.
// Loads the low bits of the write data on a write to its own offset;
// the payload type gives the field layout.

`timescale 1ns/100ps

module slink_field_reg #(
  parameter type                       payload_t   = logic [31:0],
  parameter slink_reg_pkg::reg_addr_t  OFFSET      = '0,
  parameter payload_t                  RESET_VALUE = '0
) (
  input  logic                    RegClk,
  input  logic                    RegReset,
  input  slink_reg_pkg::reg_req_t req,
  output payload_t                value
);

  import slink_reg_pkg::*;

  localparam int PAYLOAD_W = $bits(payload_t);

  logic write_hit;

  assign write_hit = reg_wr_hit(req, OFFSET);

  always_ff @(posedge RegClk or posedge RegReset) begin
    if (RegReset) begin
      value <= RESET_VALUE;
    end else if (write_hit) begin
      // upper word bits beyond the payload are dropped
      value <= payload_t'(req.wdata[PAYLOAD_W-1:0]);
    end
  end

endmodule

//--- src/slink_app_enable.sv
// Application enable registers with per-layer override select.
// Each enable is the register value when overridden, otherwise the
// external input. Also holds the debug select and its status word.

`timescale 1ns/100ps

module slink_app_enable (
  input  logic                            RegClk,
  input  logic                            RegReset,
  input  slink_reg_pkg::reg_req_t         req,
  input  slink_link_pkg::app_enable_t     ext_enable,
  output slink_link_pkg::app_enable_t     enable_muxed,
  output slink_reg_pkg::reg_data_t        debug_status,
  output slink_reg_pkg::reg_data_t [slink_link_pkg::NUM_APPS-1:0] rd_app,
  output slink_reg_pkg::reg_data_t        rd_debug_ctrl
);

  import slink_reg_pkg::*;
  import slink_link_pkg::*;

  localparam reg_addr_t APP_OFS [NUM_APPS] = '{
    OFS_APB_APP_ENABLE, OFS_AXI_APP_ENABLE, OFS_INT_APP_ENABLE};

  enable_reg_t         en_q [NUM_APPS];
  logic [NUM_APPS-1:0] ext_vec;
  logic [NUM_APPS-1:0] muxed_vec;
  debug_sel_t          dbg_sel_q;

  assign ext_vec = {ext_enable.int_app, ext_enable.axi, ext_enable.apb};

  // --------------------------------------------------
  // enable / override registers
  // --------------------------------------------------
  for (genvar i = 0; i < NUM_APPS; i++) begin : g_app
    always_ff @(posedge RegClk or posedge RegReset) begin
      if (RegReset) begin
        en_q[i] <= '0;
      end else if (reg_wr_hit(req, APP_OFS[i])) begin
        en_q[i] <= enable_reg_t'(req.wdata[1:0]);
      end
    end

    // static levels, a plain select is enough
    assign muxed_vec[i] = en_q[i].override_sel ? en_q[i].value : ext_vec[i];
    assign rd_app[i]    = REG_DATA_W'(en_q[i]);
  end

  assign enable_muxed = '{
    apb: muxed_vec[APP_APB], axi: muxed_vec[APP_AXI], int_app: muxed_vec[APP_INT]};

  // --------------------------------------------------
  // debug bus select and status
  // --------------------------------------------------
  always_ff @(posedge RegClk or posedge RegReset) begin
    if (RegReset) begin
      dbg_sel_q <= DBG_APB;
    end else if (reg_wr_hit(req, OFS_DEBUG_BUS_CTRL)) begin
      dbg_sel_q <= debug_sel_t'(req.wdata[1:0]);
    end
  end

  assign rd_debug_ctrl = REG_DATA_W'(dbg_sel_q);

  always_comb begin
    case (dbg_sel_q)
      DBG_APB: debug_status = REG_DATA_W'(muxed_vec[APP_APB]);
      DBG_AXI: debug_status = REG_DATA_W'(muxed_vec[APP_AXI]);
      DBG_INT: debug_status = REG_DATA_W'(muxed_vec[APP_INT]);
      // reserved select reads zero
      default: debug_status = '0;
    endcase
  end

endmodule

//--- src/slink_nack_status.sv
// Interrupt status with four write-one-to-clear nack flags.
// Each nack input passes a reset flop synchronizer and a rising edge of
// the synchronized level sets its flag. SYNC_STAGES must be 2 or more.

`timescale 1ns/100ps

module slink_nack_status #(
  parameter int unsigned SYNC_STAGES = 2
) (
  input  logic                        RegClk,
  input  logic                        RegReset,
  input  slink_reg_pkg::reg_req_t     req,
  input  slink_link_pkg::nack_flags_t nack_in,
  output slink_link_pkg::nack_flags_t flags,
  output slink_reg_pkg::reg_data_t    rd_status
);

  import slink_reg_pkg::*;
  import slink_link_pkg::*;

  localparam int NACK_W = $bits(nack_flags_t);

  logic [NACK_W-1:0] sync_q [SYNC_STAGES];
  logic [NACK_W-1:0] sync_prev_q;
  logic [NACK_W-1:0] rise;
  logic [NACK_W-1:0] clr;
  logic [NACK_W-1:0] flags_q;

  // --------------------------------------------------
  // synchronizer chain and edge detect
  // --------------------------------------------------
  always_ff @(posedge RegClk or posedge RegReset) begin
    if (RegReset) begin
      for (int s = 0; s < SYNC_STAGES; s++) begin
        sync_q[s] <= '0;
      end
      sync_prev_q <= '0;
    end else begin
      sync_q[0] <= nack_in;
      for (int s = 1; s < SYNC_STAGES; s++) begin
        sync_q[s] <= sync_q[s-1];
      end
      sync_prev_q <= sync_q[SYNC_STAGES-1];
    end
  end

  assign rise = sync_q[SYNC_STAGES-1] & ~sync_prev_q;

  // --------------------------------------------------
  // w1c flags
  // --------------------------------------------------
  assign clr = reg_wr_hit(req, OFS_INTERRUPT_STATUS) ? req.wdata[NACK_W-1:0] : '0;

  // clear beats a set landing on the same edge
  always_ff @(posedge RegClk or posedge RegReset) begin
    if (RegReset) begin
      flags_q <= '0;
    end else begin
      flags_q <= (flags_q | rise) & ~clr;
    end
  end

  assign flags     = nack_flags_t'(flags_q);
  assign rd_status = REG_DATA_W'(flags_q);

  // a flag only comes up once its input has crossed the synchronizer
  a_flag_needs_edge: assert property (
    @(posedge RegClk) disable iff (RegReset)
    (flags_q & ~$past(flags_q) & ~$past(nack_in, SYNC_STAGES + 1)) == '0
  );

endmodule

//--- src/slink_regs_top.sv
// Top of the serial-link APB register block.
// Connects the APB front end to the enable, nack status and
// configuration registers, and builds PRDATA and PSLVERR.

`timescale 1ns/100ps

module slink_regs_top #(
  parameter bit          PSTATE_CTRL_ENABLE_RESET = 1'b1,
  parameter int unsigned SYNC_STAGES              = 2
) (
  input  logic                         RegClk,
  input  logic                         RegReset,
  // APB
  input  logic                         PSEL,
  input  logic                         PENABLE,
  input  logic                         PWRITE,
  input  slink_reg_pkg::reg_addr_t     PADDR,
  input  slink_reg_pkg::reg_data_t     PWDATA,
  output slink_reg_pkg::reg_data_t     PRDATA,
  output logic                         PREADY,
  output logic                         PSLVERR,
  // application enables
  input  slink_link_pkg::app_enable_t  ext_enable,
  output slink_link_pkg::app_enable_t  enable_muxed,
  // nack events
  input  slink_link_pkg::nack_flags_t  nack_in,
  output slink_link_pkg::nack_flags_t  nack_flags,
  // configuration
  output slink_reg_pkg::pstate_ctrl_t  pstate_ctrl,
  output slink_reg_pkg::credit_ids_t   apb_credit_ids,
  output slink_reg_pkg::credit_ids_t   int_credit_ids,
  // debug bus
  output slink_reg_pkg::reg_data_t     debug_status
);

  import slink_reg_pkg::*;
  import slink_link_pkg::*;

  localparam pstate_ctrl_t PSTATE_RESET_VAL = '{
    ctrl_enable:      PSTATE_CTRL_ENABLE_RESET,
    pstate_req:       PSTATE_RESET.pstate_req,
    inactivity_count: PSTATE_RESET.inactivity_count,
    tick_1us:         PSTATE_RESET.tick_1us};

  reg_req_t                 req;
  reg_data_t [NUM_APPS-1:0] rd_app;
  reg_data_t                rd_debug_ctrl;
  reg_data_t                rd_status;

  // no wait states
  assign PREADY = 1'b1;

  slink_apb_front u_apb_front (
    .RegClk   (RegClk),
    .RegReset (RegReset),
    .psel     (PSEL),
    .penable  (PENABLE),
    .pwrite   (PWRITE),
    .paddr    (PADDR),
    .pwdata   (PWDATA),
    .req      (req)
  );

  slink_app_enable u_app_enable (
    .RegClk        (RegClk),
    .RegReset      (RegReset),
    .req           (req),
    .ext_enable    (ext_enable),
    .enable_muxed  (enable_muxed),
    .debug_status  (debug_status),
    .rd_app        (rd_app),
    .rd_debug_ctrl (rd_debug_ctrl)
  );

  slink_nack_status #(
    .SYNC_STAGES (SYNC_STAGES)
  ) u_nack_status (
    .RegClk    (RegClk),
    .RegReset  (RegReset),
    .req       (req),
    .nack_in   (nack_in),
    .flags     (nack_flags),
    .rd_status (rd_status)
  );

  // --------------------------------------------------
  // configuration registers
  // --------------------------------------------------
  slink_field_reg #(
    .payload_t   (pstate_ctrl_t),
    .OFFSET      (OFS_PSTATE_CONTROL),
    .RESET_VALUE (PSTATE_RESET_VAL)
  ) u_pstate_ctrl (
    .RegClk   (RegClk),
    .RegReset (RegReset),
    .req      (req),
    .value    (pstate_ctrl)
  );

  slink_field_reg #(
    .payload_t   (credit_ids_t),
    .OFFSET      (OFS_APB_CREDIT_IDS),
    .RESET_VALUE (APB_IDS_RESET)
  ) u_apb_credit_ids (
    .RegClk   (RegClk),
    .RegReset (RegReset),
    .req      (req),
    .value    (apb_credit_ids)
  );

  slink_field_reg #(
    .payload_t   (credit_ids_t),
    .OFFSET      (OFS_INT_CREDIT_IDS),
    .RESET_VALUE (INT_IDS_RESET)
  ) u_int_credit_ids (
    .RegClk   (RegClk),
    .RegReset (RegReset),
    .req      (req),
    .value    (int_credit_ids)
  );

  // --------------------------------------------------
  // read mux and error decode
  // --------------------------------------------------
  // address is held from setup, so both are stable through access
  always_comb begin
    PRDATA  = '0;
    PSLVERR = 1'b0;
    case (req.addr)
      OFS_APB_APP_ENABLE:   PRDATA = rd_app[APP_APB];
      OFS_AXI_APP_ENABLE:   PRDATA = rd_app[APP_AXI];
      OFS_INT_APP_ENABLE:   PRDATA = rd_app[APP_INT];
      OFS_INTERRUPT_STATUS: PRDATA = rd_status;
      OFS_PSTATE_CONTROL:   PRDATA = REG_DATA_W'(pstate_ctrl);
      OFS_APB_CREDIT_IDS:   PRDATA = REG_DATA_W'(apb_credit_ids);
      OFS_INT_CREDIT_IDS:   PRDATA = REG_DATA_W'(int_credit_ids);
      OFS_DEBUG_BUS_CTRL:   PRDATA = rd_debug_ctrl;
      OFS_DEBUG_BUS_STATUS: PRDATA = debug_status;
      default:              PSLVERR = 1'b1;
    endcase
  end

  // every access finishes in its first access cycle
  a_no_wait_state: assert property (
    @(posedge RegClk) disable iff (RegReset)
    PENABLE |-> PREADY ##1 !PENABLE
  );

endmodule

//--- verif/slink_regs_model.svh
// Reference model of the register block, included inside the testbench module.
// Mirrors every register and predicts read data, the error response
// and the register outputs from the register map rules.

`ifndef SLINK_REGS_MODEL_SVH
`define SLINK_REGS_MODEL_SVH

// value in bit 0, override in bit 1, index 0 = apb, 1 = axi, 2 = int
logic [1:0]  m_app [3];
logic [1:0]  m_dbg;
logic [19:0] m_pstate;
logic [31:0] m_apb_ids;
logic [31:0] m_int_ids;
logic [3:0]  m_flags;

function automatic void model_reset(input logic pstate_en);
  for (int i = 0; i < 3; i++) begin
    m_app[i] = 2'b00;
  end
  m_dbg     = 2'd0;
  m_pstate  = {pstate_en, 3'h2, 8'h05, 8'h27};
  m_apb_ids = 32'h2322_2120;
  m_int_ids = 32'h3332_3130;
  m_flags   = 4'h0;
endfunction

function automatic logic model_mapped(input logic [7:0] addr);
  case (addr)
    8'h00, 8'h04, 8'h08, 8'h0c, 8'h10, 8'h14, 8'h18, 8'h20, 8'h24: return 1'b1;
    default: return 1'b0;
  endcase
endfunction

// bit i follows the register when overridden, else the external input
function automatic logic [2:0] model_muxed(input logic [2:0] ext);
  logic [2:0] mux;
  for (int i = 0; i < 3; i++) begin
    mux[i] = m_app[i][1] ? m_app[i][0] : ext[i];
  end
  return mux;
endfunction

function automatic void model_write(input logic [7:0] addr, input logic [31:0] data);
  case (addr)
    8'h00: m_app[0] = data[1:0];
    8'h04: m_app[1] = data[1:0];
    8'h08: m_app[2] = data[1:0];
    // write one to clear
    8'h0c: m_flags = m_flags & ~data[3:0];
    8'h10: m_pstate = data[19:0];
    8'h14: m_apb_ids = data;
    8'h18: m_int_ids = data;
    8'h20: m_dbg = data[1:0];
    default: ;
  endcase
endfunction

function automatic logic [31:0] model_read(input logic [7:0] addr, input logic [2:0] ext);
  logic [2:0] mux;
  mux = model_muxed(ext);
  case (addr)
    8'h00: return 32'(m_app[0]);
    8'h04: return 32'(m_app[1]);
    8'h08: return 32'(m_app[2]);
    8'h0c: return 32'(m_flags);
    8'h10: return 32'(m_pstate);
    8'h14: return m_apb_ids;
    8'h18: return m_int_ids;
    8'h20: return 32'(m_dbg);
    8'h24: begin
      case (m_dbg)
        2'd0: return 32'(mux[0]);
        2'd1: return 32'(mux[1]);
        2'd2: return 32'(mux[2]);
        default: return 32'h0;
      endcase
    end
    default: return 32'h0;
  endcase
endfunction

`endif

//--- verif/slink_regs_tb.sv
// Testbench of the serial-link APB register block.
// Random APB traffic, enable and nack stimulus from a fixed seed,
// each response checked against the included register model.

`timescale 1ns/100ps

module slink_regs_tb;

  import slink_reg_pkg::*;
  import slink_link_pkg::*;

  localparam int          CLK_PERIOD      = 20;
  localparam int          SYNC_STAGES     = 2;
  localparam logic        PSTATE_EN_RESET = 1'b1;
  localparam logic [31:0] SEED            = 32'hebfb;

  // test lengths that set the watchdog time
  localparam int N_CFG  = 60;
  localparam int N_EN   = 20;
  localparam int N_NACK = 12;
  localparam int N_UNM  = 12;
  localparam int NUM_XFERS = 9 + 2 * N_CFG + 5 * N_EN + N_NACK * (SYNC_STAGES + 5) + 11 * N_UNM;
  localparam int POLL_MARGIN = N_NACK * (SYNC_STAGES + 2) + 20;
  localparam int WATCHDOG_CYCLES = NUM_XFERS * 4 + POLL_MARGIN;

  localparam reg_addr_t MAPPED [9] = '{8'h00, 8'h04, 8'h08, 8'h0c, 8'h10,
                                       8'h14, 8'h18, 8'h20, 8'h24};
  localparam reg_addr_t WR_OFS [8] = '{8'h00, 8'h04, 8'h08, 8'h10,
                                       8'h14, 8'h18, 8'h20, 8'h24};

  logic         RegClk;
  logic         RegReset;
  logic         PSEL;
  logic         PENABLE;
  logic         PWRITE;
  reg_addr_t    PADDR;
  reg_data_t    PWDATA;
  reg_data_t    PRDATA;
  logic         PREADY;
  logic         PSLVERR;
  app_enable_t  ext_enable;
  app_enable_t  enable_muxed;
  nack_flags_t  nack_in;
  nack_flags_t  nack_flags;
  pstate_ctrl_t pstate_ctrl;
  credit_ids_t  apb_credit_ids;
  credit_ids_t  int_credit_ids;
  reg_data_t    debug_status;

  // ext_enable as a vector with apb in bit 0
  logic [2:0] ext_vec;
  int         cycle_count;
  int         check_count;
  int         error_count;

  `include "slink_regs_model.svh"

  slink_regs_top #(
    .PSTATE_CTRL_ENABLE_RESET (PSTATE_EN_RESET),
    .SYNC_STAGES              (SYNC_STAGES)
  ) i_dut (
    .RegClk         (RegClk),
    .RegReset       (RegReset),
    .PSEL           (PSEL),
    .PENABLE        (PENABLE),
    .PWRITE         (PWRITE),
    .PADDR          (PADDR),
    .PWDATA         (PWDATA),
    .PRDATA         (PRDATA),
    .PREADY         (PREADY),
    .PSLVERR        (PSLVERR),
    .ext_enable     (ext_enable),
    .enable_muxed   (enable_muxed),
    .nack_in        (nack_in),
    .nack_flags     (nack_flags),
    .pstate_ctrl    (pstate_ctrl),
    .apb_credit_ids (apb_credit_ids),
    .int_credit_ids (int_credit_ids),
    .debug_status   (debug_status)
  );

  always begin
    #(CLK_PERIOD / 2) RegClk = ~RegClk;
  end

  always @(posedge RegClk) begin
    cycle_count <= cycle_count + 1;
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  function automatic logic [31:0] rand_word();
    return $urandom;
  endfunction

  function automatic void check_value(input string what, input logic [31:0] got,
                                      input logic [31:0] exp);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("Error: time %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endfunction

  task automatic drive_ext(input logic [2:0] v);
    ext_vec    = v;
    ext_enable = '{apb: v[0], axi: v[1], int_app: v[2]};
  endtask

  // setup, access and idle cycles with the model updated after the write edge
  task automatic apb_write(input reg_addr_t addr, input reg_data_t data);
    @(negedge RegClk);
    PSEL    = 1'b1;
    PENABLE = 1'b0;
    PWRITE  = 1'b1;
    PADDR   = addr;
    PWDATA  = data;
    @(negedge RegClk);
    PENABLE = 1'b1;
    @(negedge RegClk);
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
    model_write(addr, data);
  endtask

  // read data sampled in the middle of the access phase
  task automatic apb_read(input reg_addr_t addr, output reg_data_t data, output logic err);
    @(negedge RegClk);
    PSEL    = 1'b1;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
    PADDR   = addr;
    @(negedge RegClk);
    data    = PRDATA;
    err     = PSLVERR;
    PENABLE = 1'b1;
    @(negedge RegClk);
    PSEL    = 1'b0;
    PENABLE = 1'b0;
  endtask

  task automatic check_read(input reg_addr_t addr);
    reg_data_t rdata;
    logic      err;
    apb_read(addr, rdata, err);
    check_value($sformatf("PRDATA at 0x%02h", addr), rdata, model_read(addr, ext_vec));
    check_value($sformatf("PSLVERR at 0x%02h", addr), 32'(err), 32'(!model_mapped(addr)));
  endtask

  task automatic check_outputs();
    check_value("PREADY", 32'(PREADY), 32'h1);
    check_value("pstate_ctrl", 32'(pstate_ctrl), 32'(m_pstate));
    check_value("apb_credit_ids", 32'(apb_credit_ids), m_apb_ids);
    check_value("int_credit_ids", 32'(int_credit_ids), m_int_ids);
    check_value("enable_muxed",
                32'({enable_muxed.int_app, enable_muxed.axi, enable_muxed.apb}),
                32'(model_muxed(ext_vec)));
    check_value("debug_status", debug_status, model_read(8'h24, ext_vec));
    check_value("nack_flags", 32'(nack_flags), 32'(m_flags));
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    reg_addr_t  addr;
    reg_data_t  rdata;
    logic       err;
    logic [3:0] nack_cur;
    logic [3:0] raise;
    logic [3:0] lower;
    int         raise_cycle;
    logic       seen;

    void'($urandom(SEED));
    RegClk      = 1'b0;
    RegReset    = 1'b1;
    PSEL        = 1'b0;
    PENABLE     = 1'b0;
    PWRITE      = 1'b0;
    PADDR       = '0;
    PWDATA      = '0;
    nack_in     = '0;
    cycle_count = 0;
    check_count = 0;
    error_count = 0;
    nack_cur    = 4'h0;
    drive_ext(3'b000);
    model_reset(PSTATE_EN_RESET);
    repeat (5) @(posedge RegClk);
    @(negedge RegClk);
    RegReset = 1'b0;

    // reset values
    for (int i = 0; i < 9; i++) begin
      check_read(MAPPED[i]);
    end
    check_outputs();

    // random config, enable and debug writes with readback
    for (int n = 0; n < N_CFG; n++) begin
      addr = WR_OFS[int'(rand_word() % 8)];
      apb_write(addr, rand_word());
      check_read(addr);
      check_outputs();
    end

    // external enables against override settings
    for (int n = 0; n < N_EN; n++) begin
      drive_ext(3'(rand_word()));
      for (int i = 0; i < 3; i++) begin
        apb_write(8'(i * 4), rand_word());
      end
      apb_write(8'h20, rand_word());
      check_read(8'h24);
      check_outputs();
    end

    // nack edges, polling and w1c
    for (int n = 0; n < N_NACK; n++) begin
      if (nack_cur == 4'hf) begin
        lower = 4'hf;
      end else begin
        lower = nack_cur & 4'(rand_word());
      end
      if (lower != 4'h0) begin
        nack_cur = nack_cur & ~lower;
        nack_in  = nack_flags_t'(nack_cur);
        repeat (SYNC_STAGES + 2) @(negedge RegClk);
      end
      raise = ~nack_cur & 4'(rand_word());
      if (raise == 4'h0) begin
        raise = ~nack_cur;
      end
      nack_cur    = nack_cur | raise;
      nack_in     = nack_flags_t'(nack_cur);
      m_flags     = m_flags | raise;
      raise_cycle = cycle_count;
      seen        = 1'b0;
      while (!seen && (cycle_count - raise_cycle) <= SYNC_STAGES + 3) begin
        apb_read(8'h0c, rdata, err);
        seen = (rdata == model_read(8'h0c, ext_vec));
      end
      check_count++;
      assert (seen) else begin
        error_count++;
        $display("Error: time %0t: nack flags 0x%0h did not appear within %0d cycles",
                 $time, m_flags, SYNC_STAGES + 3);
      end
      check_outputs();
      apb_write(8'h0c, rand_word());
      check_read(8'h0c);
      check_outputs();
    end

    // unmapped offsets starting with 0x1c
    for (int n = 0; n < N_UNM; n++) begin
      if (n == 0) begin
        addr = 8'h1c;
      end else if (n % 2 == 1) begin
        addr = 8'h25 + 8'(rand_word() % 219);
      end else begin
        addr = 8'(rand_word());
        while (model_mapped(addr)) begin
          addr = 8'(rand_word());
        end
      end
      apb_write(addr, rand_word());
      check_read(addr);
      for (int i = 0; i < 9; i++) begin
        check_read(MAPPED[i]);
      end
      check_outputs();
    end

    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
    $display("Testbench failed");
    $finish;
  end

endmodule

//--- sim.f
+incdir+verif
src/slink_reg_pkg.sv
src/slink_link_pkg.sv
src/slink_apb_front.sv
src/slink_field_reg.sv
src/slink_app_enable.sv
src/slink_nack_status.sv
src/slink_regs_top.sv
verif/slink_regs_tb.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= sim.f
TOP       ?= slink_regs_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
FAIL_MSG  ?= Testbench failed
PASS_MSG  ?= Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	fi
	@echo "simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
